//--- hw/iq_cfg_pkg.sv
package iq_cfg_pkg;

    // ----------------------------------------------------------------------
    // queue geometry
    // ----------------------------------------------------------------------
    localparam int IQ_DEPTH  = 4;                       // compressed entries, slot 0 oldest
    localparam int SLOT_W    = $clog2(IQ_DEPTH);        // entry index
    localparam int CNT_W     = $clog2(IQ_DEPTH + 1);    // occupancy 0..IQ_DEPTH

    // ----------------------------------------------------------------------
    // core widths
    // ----------------------------------------------------------------------
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = $clog2(ROB_DEPTH);       // reorder buffer tag
    localparam int WORD_W    = 32;
    localparam int OP_W      = 8;                       // decoded opcode incl. mul/div

    // result buses snooped for wakeup
    // bus 0 is the alu result, bus 1 the load data
    localparam int NUM_WB    = 2;

endpackage

//--- hw/iq_types_pkg.sv
package iq_types_pkg;

    // ----------------------------------------------------------------------
    // basic words
    // ----------------------------------------------------------------------
    typedef logic [iq_cfg_pkg::TAG_W-1:0]  tag_t;
    typedef logic [iq_cfg_pkg::WORD_W-1:0] word_t;

    // producer tag in the low bits of an operand word
    typedef struct packed {
        logic [iq_cfg_pkg::WORD_W-iq_cfg_pkg::TAG_W-1:0] pad;
        tag_t                                            tag;
    } padded_tag_t;

    // same word read as a value or as the producer tag
    typedef union packed {
        word_t       value;
        padded_tag_t prod;
    } operand_u;

    // pending set means data holds a tag, clear means it holds the value
    typedef struct packed {
        logic     pending;
        operand_u data;
    } operand_t;

    // dispatched, stored and issued micro-op
    typedef struct packed {
        logic [iq_cfg_pkg::OP_W-1:0] opcode;
        word_t                       imm;
        tag_t                        dst;     // rob slot allocated at rename
        operand_t                    src1;
        operand_t                    src2;
    } uop_t;

    // ----------------------------------------------------------------------
    // writeback and wakeup
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        tag_t  tag;       // producer rob tag
        word_t result;
    } wb_bus_t;

    typedef struct packed {
        logic  hit;
        word_t data;
    } capture_t;

    typedef struct packed {
        capture_t src1;
        capture_t src2;
    } slot_capture_t;

endpackage

//--- hw/iq_wakeup.sv
`timescale 1ns/1ps

module iq_wakeup (
    input  iq_types_pkg::uop_t          entry_uop    [iq_cfg_pkg::IQ_DEPTH],
    input  logic [iq_cfg_pkg::CNT_W-1:0] count,
    input  iq_types_pkg::wb_bus_t       wb_bus       [iq_cfg_pkg::NUM_WB],
    input  iq_types_pkg::uop_t          dispatch_uop,
    output iq_types_pkg::slot_capture_t slot_capture [iq_cfg_pkg::IQ_DEPTH],
    output iq_types_pkg::slot_capture_t disp_capture
);

    // ----------------------------------------------------------------------
    // tag compare of one operand against every bus
    // ----------------------------------------------------------------------
    function automatic iq_types_pkg::capture_t match_operand(
        input iq_types_pkg::operand_t op,
        input logic                   live,
        input iq_types_pkg::wb_bus_t  bus [iq_cfg_pkg::NUM_WB]
    );
        iq_types_pkg::capture_t cap;
        cap = '0;
        // scan downwards so the lowest bus index is written last
        for (int b = iq_cfg_pkg::NUM_WB - 1; b >= 0; b--) begin
            if (live && op.pending && bus[b].valid &&
                (bus[b].tag == op.data.prod.tag)) begin
                cap.hit  = 1'b1;
                cap.data = bus[b].result;
            end
        end
        return cap;
    endfunction

    logic [iq_cfg_pkg::IQ_DEPTH-1:0] slot_live;

    always_comb begin
        for (int i = 0; i < iq_cfg_pkg::IQ_DEPTH; i++) begin
            slot_live[i] = (i < count);   // compressed, so occupied slots are 0..count-1
        end
    end

    // stored entries
    always_comb begin
        for (int i = 0; i < iq_cfg_pkg::IQ_DEPTH; i++) begin
            slot_capture[i].src1 = match_operand(entry_uop[i].src1, slot_live[i], wb_bus);
            slot_capture[i].src2 = match_operand(entry_uop[i].src2, slot_live[i], wb_bus);
        end
    end

    // same-cycle bypass for the micro-op being dispatched
    // acceptance is qualified where the entry is written
    always_comb begin
        disp_capture.src1 = match_operand(dispatch_uop.src1, 1'b1, wb_bus);
        disp_capture.src2 = match_operand(dispatch_uop.src2, 1'b1, wb_bus);
    end

endmodule

//--- hw/iq_select.sv
`timescale 1ns/1ps

module iq_select (
    input  logic [iq_cfg_pkg::IQ_DEPTH-1:0] entry_ready,
    input  logic [iq_cfg_pkg::CNT_W-1:0]    count,
    output logic [iq_cfg_pkg::SLOT_W-1:0]   grant,
    output logic                            any_ready
);

    logic [iq_cfg_pkg::IQ_DEPTH-1:0] req;

    // only occupied slots may request
    always_comb begin
        for (int i = 0; i < iq_cfg_pkg::IQ_DEPTH; i++) begin
            req[i] = entry_ready[i] && (i < count);
        end
    end

    // lowest slot is the oldest one
    always_comb begin
        grant     = '0;
        any_ready = 1'b0;
        for (int i = iq_cfg_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                grant     = i[iq_cfg_pkg::SLOT_W-1:0];
                any_ready = 1'b1;
            end
        end
    end

endmodule

//--- hw/iq_entries.sv
`timescale 1ns/1ps

module iq_entries (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             dispatch_en,
    input  iq_types_pkg::uop_t               dispatch_uop,
    input  iq_types_pkg::slot_capture_t      disp_capture,
    input  iq_types_pkg::slot_capture_t      slot_capture [iq_cfg_pkg::IQ_DEPTH],
    input  logic [iq_cfg_pkg::SLOT_W-1:0]    grant,
    input  logic                             any_ready,
    input  logic                             fu_ready,
    input  logic                             flush,
    output iq_types_pkg::uop_t               entry_uop    [iq_cfg_pkg::IQ_DEPTH],
    output logic [iq_cfg_pkg::IQ_DEPTH-1:0]  entry_ready,
    output logic [iq_cfg_pkg::CNT_W-1:0]     count,
    output logic                             iq_full,
    output logic                             issue_valid,
    output iq_types_pkg::uop_t               issue_uop
);

    // ----------------------------------------------------------------------
    // operand capture
    // ----------------------------------------------------------------------
    function automatic iq_types_pkg::operand_t merge_operand(
        input iq_types_pkg::operand_t op,
        input iq_types_pkg::capture_t cap
    );
        iq_types_pkg::operand_t res;
        res = op;
        if (cap.hit) begin
            res.pending    = 1'b0;
            res.data.value = cap.data;   // broadcast word replaces the tag
        end
        return res;
    endfunction

    function automatic iq_types_pkg::uop_t merge_uop(
        input iq_types_pkg::uop_t          uop,
        input iq_types_pkg::slot_capture_t cap
    );
        iq_types_pkg::uop_t res;
        res      = uop;
        res.src1 = merge_operand(uop.src1, cap.src1);
        res.src2 = merge_operand(uop.src2, cap.src2);
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // handshakes
    // ----------------------------------------------------------------------
    logic                         accept_disp;
    logic                         issue_fire;
    logic [iq_cfg_pkg::CNT_W-1:0] write_pos;

    assign iq_full     = (count == iq_cfg_pkg::CNT_W'(iq_cfg_pkg::IQ_DEPTH));
    assign accept_disp = dispatch_en && !iq_full && !flush;   // dropped when full
    assign issue_valid = any_ready;
    assign issue_fire  = any_ready && fu_ready;
    assign issue_uop   = entry_uop[grant];

    // dispatch lands one slot lower when the queue compresses at the same edge
    assign write_pos = issue_fire ? (count - 1'b1) : count;

    // both operands hold values
    always_comb begin
        for (int i = 0; i < iq_cfg_pkg::IQ_DEPTH; i++) begin
            entry_ready[i] = !entry_uop[i].src1.pending && !entry_uop[i].src2.pending;
        end
    end

    // ----------------------------------------------------------------------
    // next entry contents
    // ----------------------------------------------------------------------
    iq_types_pkg::uop_t uop_next [iq_cfg_pkg::IQ_DEPTH];

    always_comb begin
        for (int i = 0; i < iq_cfg_pkg::IQ_DEPTH; i++) begin
            if (accept_disp && (i == int'(write_pos))) begin
                uop_next[i] = merge_uop(dispatch_uop, disp_capture);
            end else if (issue_fire && (int'(grant) <= i) &&
                         (i < iq_cfg_pkg::IQ_DEPTH - 1)) begin
                // take the younger neighbour, keeping its wakeup
                uop_next[i] = merge_uop(entry_uop[i+1], slot_capture[i+1]);
            end else begin
                uop_next[i] = merge_uop(entry_uop[i], slot_capture[i]);
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < iq_cfg_pkg::IQ_DEPTH; i++) begin
            entry_uop[i] <= uop_next[i];
        end
    end

    // ----------------------------------------------------------------------
    // occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;                 // wins over dispatch and issue
        end else if (accept_disp && !issue_fire) begin
            count <= count + 1'b1;
        end else if (issue_fire && !accept_disp) begin
            count <= count - 1'b1;
        end
    end

endmodule

//--- hw/issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dispatch_en,
    input  iq_types_pkg::uop_t    dispatch_uop,
    output logic                  iq_full,
    input  iq_types_pkg::wb_bus_t wb_bus [iq_cfg_pkg::NUM_WB],
    input  logic                  flush,
    output logic                  issue_valid,
    output iq_types_pkg::uop_t    issue_uop,
    input  logic                  fu_ready
);

    iq_types_pkg::uop_t              entry_uop    [iq_cfg_pkg::IQ_DEPTH];
    logic [iq_cfg_pkg::IQ_DEPTH-1:0] entry_ready;
    logic [iq_cfg_pkg::CNT_W-1:0]    count;
    iq_types_pkg::slot_capture_t     slot_capture [iq_cfg_pkg::IQ_DEPTH];
    iq_types_pkg::slot_capture_t     disp_capture;
    logic [iq_cfg_pkg::SLOT_W-1:0]   grant;
    logic                            any_ready;

    // tag match against writeback
    iq_wakeup u_wakeup (
        .entry_uop    (entry_uop),
        .count        (count),
        .wb_bus       (wb_bus),
        .dispatch_uop (dispatch_uop),
        .slot_capture (slot_capture),
        .disp_capture (disp_capture)
    );

    // oldest ready pick
    iq_select u_select (
        .entry_ready (entry_ready),
        .count       (count),
        .grant       (grant),
        .any_ready   (any_ready)
    );

    iq_entries u_entries (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_en  (dispatch_en),
        .dispatch_uop (dispatch_uop),
        .disp_capture (disp_capture),
        .slot_capture (slot_capture),
        .grant        (grant),
        .any_ready    (any_ready),
        .fu_ready     (fu_ready),
        .flush        (flush),
        .entry_uop    (entry_uop),
        .entry_ready  (entry_ready),
        .count        (count),
        .iq_full      (iq_full),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop)
    );

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 2;   // 4 ns clock
    localparam int RESET_CYCLES   = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // release just after an edge, same as the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- verif/issue_queue_sva.sv
`timescale 1ns/1ps

module issue_queue_sva (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         flush,
    input logic                         issue_valid,
    input logic                         fu_ready,
    input iq_types_pkg::uop_t           issue_uop,
    input logic [iq_cfg_pkg::CNT_W-1:0] count
);

    int fail_count = 0;   // read by the testbench

    // queue is empty while in reset
    assert property (@(posedge clk) !rst_n |=> !issue_valid)
        else begin
            fail_count = fail_count + 1;
            $error("issue_valid high in the cycle after reset");
        end

    assert property (@(posedge clk) disable iff (!rst_n) flush |=> !issue_valid)
        else begin
            fail_count = fail_count + 1;
            $error("issue_valid high in the cycle after a flush");
        end

    // offer holds under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
                     issue_valid && !fu_ready && !flush |=> $stable(issue_uop))
        else begin
            fail_count = fail_count + 1;
            $error("issue_uop changed while offered and not accepted");
        end

    assert property (@(posedge clk) disable iff (!rst_n) count <= iq_cfg_pkg::IQ_DEPTH)
        else begin
            fail_count = fail_count + 1;
            $error("occupancy count above queue depth");
        end

endmodule

bind issue_queue issue_queue_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .issue_valid (issue_valid),
    .fu_ready    (fu_ready),
    .issue_uop   (issue_uop),
    .count       (count)
);

//--- verif/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;

    localparam int unsigned SEED        = 32'h1bbdcc13;
    localparam int          TEST_CYCLES = 5 + 20 + 30 + 20 + 10 + 30 + 25;   // reset + six tests
    localparam int          CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                   clk;
    logic                   rst_n;
    logic                   dispatch_en;
    iq_types_pkg::uop_t     dispatch_uop;
    logic                   iq_full;
    iq_types_pkg::wb_bus_t  wb [iq_cfg_pkg::NUM_WB];
    logic                   flush;
    logic                   issue_valid;
    iq_types_pkg::uop_t     issue_uop;
    logic                   fu_ready;

    iq_types_pkg::uop_t     model_q [$];   // oldest first
    int unsigned            cycle_cnt = 0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_queue dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_en  (dispatch_en),
        .dispatch_uop (dispatch_uop),
        .iq_full      (iq_full),
        .wb_bus       (wb),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .fu_ready     (fu_ready)
    );

    // ----------------------------------------------------------------------
    // reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_uop(input string name, input iq_types_pkg::uop_t got,
                             input iq_types_pkg::uop_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic iq_types_pkg::operand_t wake_operand(
        input iq_types_pkg::operand_t op,
        input iq_types_pkg::wb_bus_t  bus [iq_cfg_pkg::NUM_WB]
    );
        iq_types_pkg::operand_t res;
        res = op;
        for (int b = 0; b < iq_cfg_pkg::NUM_WB; b++) begin
            // first matching bus wins, later ones see pending cleared
            if (res.pending && bus[b].valid && (bus[b].tag == op.data.prod.tag)) begin
                res.pending    = 1'b0;
                res.data.value = bus[b].result;
            end
        end
        return res;
    endfunction

    function automatic iq_types_pkg::uop_t wake_uop(
        input iq_types_pkg::uop_t    uop,
        input iq_types_pkg::wb_bus_t bus [iq_cfg_pkg::NUM_WB]
    );
        iq_types_pkg::uop_t res;
        res      = uop;
        res.src1 = wake_operand(uop.src1, bus);
        res.src2 = wake_operand(uop.src2, bus);
        return res;
    endfunction

    // expected offer: oldest entry with no pending operand
    function automatic logic oldest_ready(output iq_types_pkg::uop_t exp, output int idx);
        exp = '0;
        idx = -1;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (!model_q[i].src1.pending && !model_q[i].src2.pending) begin
                exp = model_q[i];
                idx = i;
            end
        end
        return (idx >= 0);
    endfunction

    // inputs are stable at the falling edge, so compare there and
    // then apply what the next rising edge will do
    always @(negedge clk) begin : compare_proc
        iq_types_pkg::uop_t exp_uop;
        int                 exp_idx;
        logic               exp_valid;
        logic               exp_full;
        if (rst_n) begin
            if (dut0.u_sva.fail_count != 0) begin
                fail_run("a protocol assertion on the issue queue failed");
            end
            exp_full  = (model_q.size() == iq_cfg_pkg::IQ_DEPTH);
            exp_valid = oldest_ready(exp_uop, exp_idx);
            check_flag("iq_full", iq_full, exp_full);
            check_flag("issue_valid", issue_valid, exp_valid);
            if (exp_valid) begin
                check_uop("issue_uop", issue_uop, exp_uop);
            end
            if (flush) begin
                model_q.delete();
            end else begin
                for (int i = 0; i < model_q.size(); i++) begin
                    model_q[i] = wake_uop(model_q[i], wb);
                end
                if (exp_valid && fu_ready) begin
                    model_q.delete(exp_idx);
                end
                if (dispatch_en && !exp_full) begin   // dropped when full
                    model_q.push_back(wake_uop(dispatch_uop, wb));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            fail_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic iq_types_pkg::uop_t make_uop(
        input logic p1, input iq_types_pkg::tag_t t1,
        input logic p2, input iq_types_pkg::tag_t t2
    );
        iq_types_pkg::uop_t u;
        u.opcode          = iq_cfg_pkg::OP_W'($urandom());
        u.imm             = $urandom();
        u.dst             = iq_types_pkg::tag_t'($urandom());
        u.src1.pending    = p1;
        u.src1.data.value = $urandom();   // random pad above a tag
        u.src2.pending    = p2;
        u.src2.data.value = $urandom();
        if (p1) u.src1.data.prod.tag = t1;
        if (p2) u.src2.data.prod.tag = t2;
        return u;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        dispatch_en = 1'b0;
        flush       = 1'b0;
        for (int b = 0; b < iq_cfg_pkg::NUM_WB; b++) begin
            wb[b] = '0;
        end
    endtask

    task automatic set_bus(input int idx, input iq_types_pkg::tag_t tag,
                           input iq_types_pkg::word_t word);
        wb[idx].valid  = 1'b1;
        wb[idx].tag    = tag;
        wb[idx].result = word;
    endtask

    task automatic cycle_idle();
        next_cycle();
        idle_inputs();
    endtask

    task automatic cycle_dispatch(input iq_types_pkg::uop_t u);
        cycle_idle();
        dispatch_en  = 1'b1;
        dispatch_uop = u;
    endtask

    task automatic cycle_broadcast(input int idx, input iq_types_pkg::tag_t tag);
        cycle_idle();
        set_bus(idx, tag, $urandom());
    endtask

    task automatic drain_queue();
        cycle_idle();
        while (model_q.size() != 0) begin
            cycle_idle();
        end
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        dispatch_en  = 1'b0;
        dispatch_uop = '0;
        flush        = 1'b0;
        fu_ready     = 1'b0;
        for (int b = 0; b < iq_cfg_pkg::NUM_WB; b++) begin
            wb[b] = '0;
        end
        @(posedge rst_n);

        // in-order issue of ready micro-ops
        fu_ready = 1'b1;
        repeat (4) cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        drain_queue();

        // pending operand, wakeup on bus 1, then double match on both buses
        cycle_dispatch(make_uop(1'b1, 4'h2, 1'b0, '0));
        cycle_broadcast(0, 4'h6);                  // unrelated tag
        repeat (2) cycle_idle();
        cycle_broadcast(1, 4'h2);
        drain_queue();
        cycle_dispatch(make_uop(1'b0, '0, 1'b1, 4'h4));
        repeat (2) cycle_idle();
        cycle_broadcast(0, 4'h4);
        set_bus(1, 4'h4, $urandom());              // bus 0 should win
        drain_queue();

        // younger ready overtakes older pending
        cycle_dispatch(make_uop(1'b1, 4'h3, 1'b0, '0));
        cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        repeat (2) cycle_idle();
        cycle_broadcast(0, 4'h3);
        drain_queue();

        // broadcast in the dispatch cycle of its consumer
        cycle_dispatch(make_uop(1'b1, 4'h7, 1'b1, 4'h8));
        set_bus(0, 4'h7, $urandom());
        set_bus(1, 4'h8, $urandom());
        drain_queue();

        // fill up under back-pressure, fifth dispatch dropped
        fu_ready = 1'b0;
        repeat (5) cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        repeat (3) cycle_idle();
        cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        fu_ready = 1'b1;                           // issue and dropped dispatch together
        drain_queue();

        // flush wins over issue and dispatch, queue works again afterwards
        fu_ready = 1'b0;
        cycle_dispatch(make_uop(1'b1, 4'h9, 1'b0, '0));
        cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        cycle_dispatch(make_uop(1'b0, '0, 1'b1, 4'ha));
        cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        cycle_idle();
        flush    = 1'b1;                           // full queue, offer taken at the same edge
        fu_ready = 1'b1;
        cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        flush = 1'b1;                              // empty queue, dispatch at the same edge
        cycle_idle();
        repeat (2) cycle_dispatch(make_uop(1'b0, '0, 1'b0, '0));
        drain_queue();

        repeat (2) cycle_idle();
        if (dut0.u_sva.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run("a protocol assertion on the issue queue failed");
        end
    end

endmodule

//--- all.f
hw/iq_cfg_pkg.sv
hw/iq_types_pkg.sv
hw/iq_wakeup.sv
hw/iq_select.sv
hw/iq_entries.sv
hw/issue_queue.sv
verif/tb_clkgen.sv
verif/issue_queue_sva.sv
verif/tb_issue_queue.sv
